// File: design/tcm_trb_params.svh
// width, depth and length macros for the traceback back end
`ifndef TCM_TRB_PARAMS_SVH
`define TCM_TRB_PARAMS_SVH

// --------------------------------------------------------------------------
// trellis
// --------------------------------------------------------------------------

// three-bit shift register, 8 states
`define TRB_STATE_W 3

// --------------------------------------------------------------------------
// memories
// --------------------------------------------------------------------------

// survivor ram address bits, 64 trellis steps deep
`define TRB_RAM_AW 6

// longest traceback block, also the depth of one reversal bank
`define TRB_MAX_LEN 16

`endif

// File: design/tcm_trb_pkg.sv
// traceback types and the trellis predecessor rule
`include "tcm_trb_params.svh"

package tcm_trb_pkg;

  // --------------------------------------------------------------------------
  // data types
  // --------------------------------------------------------------------------

  // last three input bits, newest in bit 0
  typedef logic [`TRB_STATE_W-1:0] state_t;

  // one survivor bit per state
  typedef logic [(1 << `TRB_STATE_W)-1:0] decision_t;

  // circular survivor ram address
  typedef logic [`TRB_RAM_AW-1:0] trb_ram_addr_t;

  // position inside one reversal bank
  typedef logic [$clog2(`TRB_MAX_LEN)-1:0] lifo_addr_t;

  // decision bit on top, predecessor lsb below
  typedef logic [1:0] bm_idx_t;

  // --------------------------------------------------------------------------
  // trellis
  // --------------------------------------------------------------------------

  // predecessor of s for decision d
  // d is the bit that dropped out of the register
  function automatic state_t pre_state(input state_t s, input logic d);
    return {d, s[`TRB_STATE_W-1:1]};
  endfunction

endpackage

// File: design/tcm_trb_survivor_ram.sv
// survivor decision memory with write pointer and two-cycle read
`timescale 1ns/10ps
`include "tcm_trb_params.svh"

module tcm_trb_survivor_ram (
  input  logic                       iclk,
  input  logic                       ireset,
  // acs side
  input  logic                       iwrite,
  input  tcm_trb_pkg::decision_t     idecision,
  // traceback side
  input  tcm_trb_pkg::trb_ram_addr_t raddr,
  output tcm_trb_pkg::decision_t     rdecision,
  // newest free step
  output tcm_trb_pkg::trb_ram_addr_t owptr
);

  import tcm_trb_pkg::*;

  localparam int ram_depth = 1 << `TRB_RAM_AW;

  decision_t     mem [ram_depth];
  trb_ram_addr_t wptr;
  trb_ram_addr_t raddr_q;

  // --------------------------------------------------------------------------
  // write side
  // --------------------------------------------------------------------------

  // pointer wraps at the ram depth
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr <= '0;
    end
    else if (iwrite) begin
      wptr <= wptr + 1'b1;
    end
  end

  always_ff @(posedge iclk) begin
    if (iwrite) begin
      mem[wptr] <= idecision;
    end
  end

  assign owptr = wptr;

  // --------------------------------------------------------------------------
  // read side
  // --------------------------------------------------------------------------

  // address reg then data reg, fixed latency of 2
  always_ff @(posedge iclk) begin
    raddr_q   <= raddr;
    rdecision <= mem[raddr_q];
  end

endmodule

// File: design/tcm_trb_engine.sv
// traceback engine: command select, address count, read pipeline, state walk
`timescale 1ns/10ps

module tcm_trb_engine (
  input  logic                       iclk,
  input  logic                       ireset,
  // normal traceback command
  input  logic                       istart,
  input  tcm_trb_pkg::trb_ram_addr_t iraddr,
  input  tcm_trb_pkg::trb_ram_addr_t isize_m1,
  input  tcm_trb_pkg::state_t        istate,
  // flush command
  input  logic                       iflush,
  input  tcm_trb_pkg::trb_ram_addr_t ifraddr,
  input  tcm_trb_pkg::trb_ram_addr_t ifsize_m1,
  input  tcm_trb_pkg::state_t        ifstate,
  output logic                       ordy,
  // survivor ram
  output tcm_trb_pkg::trb_ram_addr_t raddr,
  input  tcm_trb_pkg::decision_t     rdecision,
  // reversal buffer
  output logic                       wr,
  output logic                       wsop,
  output logic                       weop,
  output logic                       wflush,
  output logic                       wbit,
  output tcm_trb_pkg::bm_idx_t       wbm_idx
);

  import tcm_trb_pkg::*;

  logic          do_start;
  logic          busy;
  logic          first;
  logic          last;
  logic          cmd_flush;
  trb_ram_addr_t cnt;
  trb_ram_addr_t sel_size;
  state_t        start_state;
  // two ram stages, wr and friends form the third
  logic [1:0]    pipe_val;
  logic [1:0]    pipe_sop;
  logic [1:0]    pipe_eop;
  logic [1:0]    pipe_flush;
  state_t        pipe_state [2];
  state_t        state;
  state_t        cur_state;
  state_t        prev_state;
  logic          dbit;

  // --------------------------------------------------------------------------
  // command accept and address count
  // --------------------------------------------------------------------------

  // istart has priority over iflush
  assign do_start = ordy & (istart | iflush);
  assign sel_size = istart ? isize_m1 : ifsize_m1;

  // ready again while the last address goes out
  assign ordy = ~busy | last;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy      <= 1'b0;
      first     <= 1'b0;
      last      <= 1'b0;
      cmd_flush <= 1'b0;
      cnt       <= '0;
    end
    else begin
      first <= do_start;
      if (do_start) begin
        busy      <= 1'b1;
        cmd_flush <= ~istart;
        cnt       <= sel_size;
        last      <= (sel_size == '0);
      end
      else if (busy) begin
        busy <= ~last;
        cnt  <= cnt - 1'b1;
        last <= (cnt == trb_ram_addr_t'(1));
      end
    end
  end

  // newest step first, wraps modulo ram depth
  always_ff @(posedge iclk) begin
    if (do_start) begin
      raddr       <= istart ? iraddr : ifraddr;
      start_state <= istart ? istate : ifstate;
    end
    else if (busy) begin
      raddr <= raddr - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // markers follow the ram latency
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      pipe_val   <= '0;
      pipe_sop   <= '0;
      pipe_eop   <= '0;
      pipe_flush <= '0;
    end
    else begin
      pipe_val   <= {pipe_val[0], busy};
      pipe_sop   <= {pipe_sop[0], first};
      pipe_eop   <= {pipe_eop[0], last};
      pipe_flush <= {pipe_flush[0], last & cmd_flush};
    end
  end

  // start state delayed too, a size-0 block lets the next command overwrite it
  always_ff @(posedge iclk) begin
    pipe_state[0] <= start_state;
    pipe_state[1] <= pipe_state[0];
  end

  // --------------------------------------------------------------------------
  // state walk
  // --------------------------------------------------------------------------

  assign cur_state  = pipe_sop[1] ? pipe_state[1] : state;
  assign dbit       = rdecision[cur_state];
  assign prev_state = pre_state(cur_state, dbit);

  // decoded bit is the lsb of the state we stand on
  always_ff @(posedge iclk) begin
    if (pipe_val[1]) begin
      state   <= prev_state;
      wbit    <= cur_state[0];
      wbm_idx <= {dbit, prev_state[0]};
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr     <= 1'b0;
      wsop   <= 1'b0;
      weop   <= 1'b0;
      wflush <= 1'b0;
    end
    else begin
      wr     <= pipe_val[1];
      wsop   <= pipe_val[1] & pipe_sop[1];
      weop   <= pipe_eop[1];
      wflush <= pipe_flush[1];
    end
  end

endmodule

// File: design/tcm_trb_reorder_lifo.sv
// two-bank reversal buffer replaying traceback blocks in forward order
`timescale 1ns/10ps
`include "tcm_trb_params.svh"

module tcm_trb_reorder_lifo (
  input  logic                 iclk,
  input  logic                 ireset,
  // from the engine, newest step first
  input  logic                 wr,
  input  logic                 wsop,
  input  logic                 weop,
  input  logic                 wflush,
  input  logic                 wbit,
  input  tcm_trb_pkg::bm_idx_t wbm_idx,
  // forward-order stream
  output logic                 oval,
  output logic                 osop,
  output logic                 oeop,
  output logic                 oframe_end,
  output logic                 obit,
  output tcm_trb_pkg::bm_idx_t obm_idx
);

  import tcm_trb_pkg::*;

  localparam int bank_depth = `TRB_MAX_LEN;

  // bank select on top of the position
  logic [2:0] mem [2*bank_depth];
  lifo_addr_t blk_len_m1 [2];
  logic       blk_flush [2];
  logic [1:0] ready;
  logic       wbank;
  lifo_addr_t wcnt;
  lifo_addr_t wpos;
  logic       weop_in;
  logic       rsel;
  logic       rbank;
  logic       rd_busy;
  logic       rd_first;
  logic       rd_flush;
  logic       rd_last;
  lifo_addr_t rptr;
  logic       hit;
  logic       start;
  lifo_addr_t start_len;
  logic       start_flush;

  // --------------------------------------------------------------------------
  // write side
  // --------------------------------------------------------------------------

  assign wpos    = wsop ? '0 : wcnt;
  assign weop_in = wr & weop;

  // block finishing this very edge in the bank we read next
  assign hit         = weop_in & (wbank == rsel);
  assign start_len   = hit ? wpos : blk_len_m1[rsel];
  assign start_flush = hit ? wflush : blk_flush[rsel];

  // --------------------------------------------------------------------------
  // read side
  // --------------------------------------------------------------------------

  // read from the top down, back to back if the other bank is ready
  assign rd_last = rd_busy & (rptr == '0);
  assign start   = (~rd_busy | rd_last) & (ready[rsel] | hit);

  always_ff @(posedge iclk) begin
    if (wr) begin
      mem[{wbank, wpos}] <= {wbit, wbm_idx};
    end
    if (weop_in) begin
      blk_len_m1[wbank] <= wpos;
      blk_flush[wbank]  <= wflush;
    end
    if (rd_busy) begin
      {obit, obm_idx} <= mem[{rbank, rptr}];
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wcnt       <= '0;
      wbank      <= 1'b0;
      ready      <= '0;
      rsel       <= 1'b0;
      rbank      <= 1'b0;
      rd_busy    <= 1'b0;
      rd_first   <= 1'b0;
      rd_flush   <= 1'b0;
      rptr       <= '0;
      oval       <= 1'b0;
      osop       <= 1'b0;
      oeop       <= 1'b0;
      oframe_end <= 1'b0;
    end
    else begin
      if (wr) begin
        wcnt <= wpos + 1'b1;
      end
      // finished bank handed to the reader
      if (weop_in) begin
        wbank        <= ~wbank;
        ready[wbank] <= 1'b1;
      end
      if (start) begin
        ready[rsel] <= 1'b0;
        rsel        <= ~rsel;
        rbank       <= rsel;
        rptr        <= start_len;
        rd_flush    <= start_flush;
        rd_first    <= 1'b1;
        rd_busy     <= 1'b1;
      end
      else begin
        rd_first <= 1'b0;
        if (rd_busy) begin
          rptr <= rptr - 1'b1;
        end
        if (rd_last) begin
          rd_busy <= 1'b0;
        end
      end
      oval       <= rd_busy;
      osop       <= rd_busy & rd_first;
      oeop       <= rd_last;
      oframe_end <= rd_last & rd_flush;
    end
  end

endmodule

// File: design/tcm_trb_top.sv
// top level: survivor ram, traceback engine and reversal buffer
`timescale 1ns/10ps

module tcm_trb_top (
  input  logic                       iclk,
  input  logic                       ireset,
  // decision input
  input  logic                       iwrite,
  input  tcm_trb_pkg::decision_t     idecision,
  output tcm_trb_pkg::trb_ram_addr_t owptr,
  // commands
  input  logic                       istart,
  input  tcm_trb_pkg::trb_ram_addr_t iraddr,
  input  tcm_trb_pkg::trb_ram_addr_t isize_m1,
  input  tcm_trb_pkg::state_t        istate,
  input  logic                       iflush,
  input  tcm_trb_pkg::trb_ram_addr_t ifraddr,
  input  tcm_trb_pkg::trb_ram_addr_t ifsize_m1,
  input  tcm_trb_pkg::state_t        ifstate,
  output logic                       ordy,
  // decoded stream
  output logic                       oval,
  output logic                       osop,
  output logic                       oeop,
  output logic                       oframe_end,
  output logic                       obit,
  output tcm_trb_pkg::bm_idx_t       obm_idx
);

  import tcm_trb_pkg::*;

  // engine to ram
  trb_ram_addr_t raddr;
  decision_t     rdecision;
  // engine to reversal buffer
  logic          wr;
  logic          wsop;
  logic          weop;
  logic          wflush;
  logic          wbit;
  bm_idx_t       wbm_idx;

  tcm_trb_survivor_ram tcm_trb_survivor_ram_inst (
    .iclk      (iclk),
    .ireset    (ireset),
    .iwrite    (iwrite),
    .idecision (idecision),
    .raddr     (raddr),
    .rdecision (rdecision),
    .owptr     (owptr)
  );

  tcm_trb_engine tcm_trb_engine_inst (
    .iclk      (iclk),
    .ireset    (ireset),
    .istart    (istart),
    .iraddr    (iraddr),
    .isize_m1  (isize_m1),
    .istate    (istate),
    .iflush    (iflush),
    .ifraddr   (ifraddr),
    .ifsize_m1 (ifsize_m1),
    .ifstate   (ifstate),
    .ordy      (ordy),
    .raddr     (raddr),
    .rdecision (rdecision),
    .wr        (wr),
    .wsop      (wsop),
    .weop      (weop),
    .wflush    (wflush),
    .wbit      (wbit),
    .wbm_idx   (wbm_idx)
  );

  tcm_trb_reorder_lifo tcm_trb_reorder_lifo_inst (
    .iclk       (iclk),
    .ireset     (ireset),
    .wr         (wr),
    .wsop       (wsop),
    .weop       (weop),
    .wflush     (wflush),
    .wbit       (wbit),
    .wbm_idx    (wbm_idx),
    .oval       (oval),
    .osop       (osop),
    .oeop       (oeop),
    .oframe_end (oframe_end),
    .obit       (obit),
    .obm_idx    (obm_idx)
  );

endmodule

// File: verification/tcm_trb_assertions.sv
// concurrent checks on the engine to reversal buffer link and on the decoded stream
`timescale 1ns/10ps

module tcm_trb_assertions (
  input logic iclk,
  input logic ireset,
  input logic istart,
  input logic iflush,
  input logic ordy,
  input logic wr,
  input logic wsop,
  input logic weop,
  input logic osop,
  input logic oeop,
  input logic oframe_end
);

  // failures seen, read by the testbench at the end
  int   fails = 0;
  logic acc;

  // command taken on this edge
  assign acc = ordy && (istart || iflush);

  // --------------------------------------------------------------------------
  // engine
  // --------------------------------------------------------------------------

  // first write beat three cycles after the accepting edge
  wr_latency: assert property (@(posedge iclk) disable iff (ireset)
    $past(acc, 4) |-> (wr && wsop))
    else begin
      $error("wr did not start three cycles after an accepted command");
      fails++;
    end

  // every block start goes back to a command taken with ordy high
  accept_rdy: assert property (@(posedge iclk) disable iff (ireset)
    wsop |-> $past(acc, 4))
    else begin
      $error("block started without a command accepted while ordy was high");
      fails++;
    end

  // no gap inside a block
  wr_contig: assert property (@(posedge iclk) disable iff (ireset)
    $past(wr && !weop) |-> wr)
    else begin
      $error("wr dropped before the end of a block");
      fails++;
    end

  // --------------------------------------------------------------------------
  // reversal buffer
  // --------------------------------------------------------------------------

  frame_end_eop: assert property (@(posedge iclk) disable iff (ireset)
    (osop && oframe_end) |-> oeop)
    else begin
      $error("osop with oframe_end but without oeop");
      fails++;
    end

endmodule

// attached where the engine and the reversal buffer meet
bind tcm_trb_top tcm_trb_assertions tcm_trb_assertions_inst (
  .iclk       (iclk),
  .ireset     (ireset),
  .istart     (istart),
  .iflush     (iflush),
  .ordy       (ordy),
  .wr         (wr),
  .wsop       (wsop),
  .weop       (weop),
  .osop       (osop),
  .oeop       (oeop),
  .oframe_end (oframe_end)
);

// File: verification/tcm_trb_tb.sv
// clock, reset, random survivor stream, commands, reference traceback and comparator
`timescale 1ns/10ps
`include "tcm_trb_params.svh"

module tcm_trb_tb;

  import tcm_trb_pkg::*;

  localparam int ram_depth    = 1 << `TRB_RAM_AW;
  localparam int reset_cycles = 8;
  localparam int idle_cycles  = 6;
  localparam int n_steps      = 72;
  localparam int n_blocks     = 5;
  localparam int quiet_cycles = 30;
  // per block a wait for ordy, the traceback, 5 cycles of latency, the readout and slack
  localparam int cycle_limit  = reset_cycles + idle_cycles + n_steps
                                + n_blocks * (2 * `TRB_MAX_LEN + 9) + quiet_cycles + 100;

  logic          iclk;
  logic          ireset;
  logic          iwrite;
  decision_t     idecision;
  trb_ram_addr_t owptr;
  logic          istart;
  trb_ram_addr_t iraddr;
  trb_ram_addr_t isize_m1;
  state_t        istate;
  logic          iflush;
  trb_ram_addr_t ifraddr;
  trb_ram_addr_t ifsize_m1;
  state_t        ifstate;
  logic          ordy;
  logic          oval;
  logic          osop;
  logic          oeop;
  logic          oframe_end;
  logic          obit;
  bm_idx_t       obm_idx;

  // model copy of the ram and the true input path, indexed by address
  decision_t     model_dec [ram_depth];
  logic          true_bit [ram_depth];
  state_t        true_state [ram_depth];
  // expected beat holds frame_end, eop, sop, bit and branch index
  logic [5:0]    exp_beat [$];
  string         exp_name [$];
  logic [31:0]   rng_state = 32'h55540f2f;
  int            errors = 0;
  int            checks = 0;
  int            cycles = 0;

  tcm_trb_top tcm_trb_top_inst (
    .iclk       (iclk),
    .ireset     (ireset),
    .iwrite     (iwrite),
    .idecision  (idecision),
    .owptr      (owptr),
    .istart     (istart),
    .iraddr     (iraddr),
    .isize_m1   (isize_m1),
    .istate     (istate),
    .iflush     (iflush),
    .ifraddr    (ifraddr),
    .ifsize_m1  (ifsize_m1),
    .ifstate    (ifstate),
    .ordy       (ordy),
    .oval       (oval),
    .osop       (osop),
    .oeop       (oeop),
    .oframe_end (oframe_end),
    .obit       (obit),
    .obm_idx    (obm_idx)
  );

  always #2 iclk = ~iclk;

  // --------------------------------------------------------------------------
  // random source and reference traceback
  // --------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // walks the model copy back from the newest step and returns forward order
  function automatic void ref_traceback(input int newest, input int len,
                                        input state_t from_state,
                                        output logic [`TRB_MAX_LEN-1:0] bits,
                                        output logic [2*`TRB_MAX_LEN-1:0] bms);
    state_t s;
    logic   d;
    int     k;
    int     pos;
    s    = from_state;
    bits = '0;
    bms  = '0;
    for (k = 0; k < len; k++) begin
      d   = model_dec[(newest - k + ram_depth) % ram_depth][s];
      pos = len - 1 - k;
      bits[pos]       = s[0];
      bms[2*pos +: 2] = {d, s[1]};
      // predecessor has the decision bit on top and the state shifted down
      s = {d, s[`TRB_STATE_W-1:1]};
    end
  endfunction

  // --------------------------------------------------------------------------
  // stimulus tasks
  // --------------------------------------------------------------------------

  task automatic write_steps(input int n);
    state_t    s;
    state_t    ns;
    decision_t dec;
    logic      b;
    int        t;
    s = '0;
    for (t = 0; t < n; t++) begin
      rng_state = xorshift32(rng_state);
      b   = rng_state[0];
      dec = rng_state[15:8];
      ns  = {s[`TRB_STATE_W-2:0], b};
      // true state keeps the bit that fell out of the register
      dec[ns] = s[`TRB_STATE_W-1];
      @(negedge iclk);
      iwrite    = 1'b1;
      idecision = dec;
      model_dec[t % ram_depth]  = dec;
      true_bit[t % ram_depth]   = b;
      true_state[t % ram_depth] = ns;
      s = ns;
    end
    @(negedge iclk);
    iwrite = 1'b0;
  endtask

  task automatic issue_cmd(input string name, input logic is_flush, input int newest,
                           input int len);
    state_t                    st;
    logic [`TRB_MAX_LEN-1:0]   bits;
    logic [2*`TRB_MAX_LEN-1:0] bms;
    logic                      want;
    int                        k;
    st = true_state[newest];
    ref_traceback(newest, len, st, bits, bms);
    // from the true final state the model must give back the input bits
    for (k = 0; k < len; k++) begin
      want = true_bit[(newest - len + 1 + k + ram_depth) % ram_depth];
      assert (bits[k] == want) else begin
        errors++;
        $display("ERR %s model bit %0d expected %0d actual %0d", name, k, want, bits[k]);
      end
    end
    do @(negedge iclk); while (!ordy);
    if (is_flush) begin
      iflush    = 1'b1;
      ifraddr   = trb_ram_addr_t'(newest);
      ifsize_m1 = trb_ram_addr_t'(len - 1);
      ifstate   = st;
    end
    else begin
      istart   = 1'b1;
      iraddr   = trb_ram_addr_t'(newest);
      isize_m1 = trb_ram_addr_t'(len - 1);
      istate   = st;
    end
    // beats queued on the accepting edge
    @(posedge iclk);
    for (k = 0; k < len; k++) begin
      exp_beat.push_back({is_flush && k == len - 1, k == len - 1, k == 0,
                          bits[k], bms[2*k +: 2]});
      exp_name.push_back(name);
    end
    @(negedge iclk);
    istart = 1'b0;
    iflush = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // comparator
  // --------------------------------------------------------------------------

  always @(negedge iclk) begin : compare
    logic [5:0] e;
    string      nm;
    if (!ireset) begin
      assert (oval || !(osop || oeop || oframe_end)) else begin
        errors++;
        $display("sop, eop or frame end raised while oval was low");
      end
      if (oval) begin
        assert (exp_beat.size() != 0) else begin
          errors++;
          $display("output beat arrived with no traceback block pending");
        end
        if (exp_beat.size() != 0) begin
          e  = exp_beat.pop_front();
          nm = exp_name.pop_front();
          checks++;
          assert (obit == e[2]) else begin
            errors++;
            $display("ERR %s obit expected %0d actual %0d", nm, e[2], obit);
          end
          assert (obm_idx == e[1:0]) else begin
            errors++;
            $display("ERR %s obm_idx expected %0d actual %0d", nm, e[1:0], obm_idx);
          end
          assert ({oframe_end, oeop, osop} == e[5:3]) else begin
            errors++;
            $display("ERR %s frame_end/eop/sop expected %b actual %b", nm, e[5:3],
                     {oframe_end, oeop, osop});
          end
        end
      end
    end
  end

  // limit comes from the steps, the block lengths and the latency
  initial begin : watchdog
    while (cycles < cycle_limit) begin
      @(posedge iclk);
      cycles++;
    end
    $display("timeout after %0d cycles, decoded output never completed", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin : main
    iclk      = 1'b0;
    ireset    = 1'b1;
    iwrite    = 1'b0;
    idecision = '0;
    istart    = 1'b0;
    iraddr    = '0;
    isize_m1  = '0;
    istate    = '0;
    iflush    = 1'b0;
    ifraddr   = '0;
    ifsize_m1 = '0;
    ifstate   = '0;
    repeat (reset_cycles) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    // idle after reset
    repeat (idle_cycles) begin
      @(negedge iclk);
      assert (ordy && !oval) else begin
        errors++;
        $display("after reset ordy should be high and oval low");
      end
    end

    // 72 steps so the ram has wrapped once
    write_steps(n_steps);
    assert (owptr == trb_ram_addr_t'(n_steps % ram_depth)) else begin
      errors++;
      $display("ERR write_steps owptr expected %0d actual %0d", n_steps % ram_depth, owptr);
    end

    issue_cmd("block16", 1'b0, 40, 16);
    issue_cmd("flush5", 1'b1, 50, 5);

    // two banks hold only two blocks in flight
    while (exp_beat.size() != 0) @(negedge iclk);

    // back to back pair with a stray strobe while busy
    issue_cmd("b2b_first", 1'b0, 30, 16);
    @(negedge iclk);
    assert (!ordy) else begin
      errors++;
      $display("ordy was high during a running traceback");
    end
    istart   = 1'b1;
    iraddr   = trb_ram_addr_t'(10);
    isize_m1 = trb_ram_addr_t'(3);
    @(negedge iclk);
    istart = 1'b0;
    issue_cmd("b2b_second", 1'b1, 60, 12);

    while (exp_beat.size() != 0) @(negedge iclk);

    // newest step 69 sits at address 5 and the range wraps past 0
    issue_cmd("wrap", 1'b0, 5, 16);

    while (exp_beat.size() != 0) @(negedge iclk);
    repeat (quiet_cycles) @(negedge iclk);

    $display("checks %0d errors %0d assertion failures %0d", checks, errors,
             tcm_trb_top_inst.tcm_trb_assertions_inst.fails);
    if (errors == 0 && tcm_trb_top_inst.tcm_trb_assertions_inst.fails == 0) begin
      $display("*** PASSED ***");
    end
    else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+design
design/tcm_trb_pkg.sv
design/tcm_trb_survivor_ram.sv
design/tcm_trb_engine.sv
design/tcm_trb_reorder_lifo.sv
design/tcm_trb_top.sv
verification/tcm_trb_assertions.sv
verification/tcm_trb_tb.sv

// File: Makefile
# Verilator build and run of the traceback back end testbench
VERILATOR ?= verilator
TOP       ?= tcm_trb_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := *** PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST)) design/tcm_trb_params.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
